// File: gram_arb.f
+incdir+source
source/gram_cmd_pkg.sv
source/gram_plan_pkg.sv
source/gram_req_pipe.sv
source/gram_slot_timer.sv
source/gram_arb_decide.sv
source/gram_plan_table.sv
source/gram_arb_top.sv
bench/gram_arb_checks.sv
bench/gram_arb_tb.sv

// File: Bender.yml
package:
  name: gram_arb

sources:
  - include_dirs:
      - source
    files:
      - source/gram_cmd_pkg.sv
      - source/gram_plan_pkg.sv
      - source/gram_req_pipe.sv
      - source/gram_slot_timer.sv
      - source/gram_arb_decide.sv
      - source/gram_plan_table.sv
      - source/gram_arb_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/gram_arb_checks.sv
      - bench/gram_arb_tb.sv

// File: bench/gram_arb_tb.sv
// --------------------
// GRAM arbiter testbench
// Random feed and accumulator traffic, checker does the comparing
// --------------------

`timescale 1ns/100ps

`include "gram_arb_defines.svh"

module gram_arb_tb
  import gram_cmd_pkg::*;
  import gram_plan_pkg::*;
();

  localparam int WAIT_LIMIT = 400;

  logic                clk;
  logic                s_rst_n;
  gram_cmd_t           feed_req_i;
  logic                feed_req_vld_i;
  logic                feed_req_rdy_o;
  gram_cmd_t           acc_req_i;
  logic                acc_req_vld_i;
  logic                acc_req_rdy_o;
  logic                feed_grant_o;
  logic                acc_grant_o;
  logic [`GRAM_NB-1:0] feed_rot_avail_o;
  logic [`GRAM_NB-1:0] feed_dat_avail_o;
  logic [`GRAM_NB-1:0] acc_rd_avail_o;
  logic [`GRAM_NB-1:0] acc_wr_avail_o;
  logic [`GRAM_NB-1:0] sxt_avail_o;
  logic [`GRAM_NB-1:0] ldg_avail_o;
  int                  tests_run;
  int                  tests_failed;
  int                  err_start;

  gram_arb_top dut0 (.*);
  gram_arb_checks chk0 (.*);

  // 40 ns clock
  always #20 clk = ~clk;

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    $display("Test failures found");
    $finish;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = chk0.err_cnt - err_start;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("%s: %0d errors", name, errs);
    err_start = chk0.err_cnt;
  endtask

  // Random grid index
  function automatic logic [`GRAM_ID_W-1:0] rand_grid();
    int unsigned r;
    r = $urandom;
    return r[`GRAM_ID_W-1:0];
  endfunction

  // Hold valid until the pipe takes the command
  task automatic send_acc(input logic [`GRAM_ID_W-1:0] grid);
    int t;
    t = 0;
    @(negedge clk);
    acc_req_i.grid = grid;
    acc_req_vld_i  = 1'b1;
    while (!acc_req_rdy_o) begin
      @(negedge clk);
      t++;
      if (t > WAIT_LIMIT) abort_run("accumulator command never accepted");
    end
    @(negedge clk);
    acc_req_vld_i = 1'b0;
  endtask

  task automatic send_feed(input logic [`GRAM_ID_W-1:0] grid);
    int t;
    t = 0;
    @(negedge clk);
    feed_req_i.grid = grid;
    feed_req_vld_i  = 1'b1;
    while (!feed_req_rdy_o) begin
      @(negedge clk);
      t++;
      if (t > WAIT_LIMIT) abort_run("feed command never accepted");
    end
    @(negedge clk);
    feed_req_vld_i = 1'b0;
  endtask

  // Both pipes empty, then let the longest booking run out
  task automatic drain;
    int t;
    t = 0;
    while (!(acc_req_rdy_o && feed_req_rdy_o)) begin
      @(negedge clk);
      t++;
      if (t > WAIT_LIMIT) abort_run("a held command was never granted");
    end
    repeat (`GARB_SLOT_CYCLE * `GARB_SLOT_NB) @(negedge clk);
  endtask

  initial begin
    logic [`GRAM_ID_W-1:0] grid;
    clk            = 1'b0;
    s_rst_n        = 1'b0;
    feed_req_i     = '0;
    feed_req_vld_i = 1'b0;
    acc_req_i      = '0;
    acc_req_vld_i  = 1'b0;
    tests_run      = 0;
    tests_failed   = 0;
    err_start      = 0;
    void'($urandom(32'hd874));
    repeat (3) @(posedge clk);
    @(negedge clk);
    s_rst_n = 1'b1;
    repeat (2) @(negedge clk);
    end_test("reset");
    repeat (5 * `GARB_SLOT_CYCLE) @(negedge clk);
    end_test("idle_fill");
    for (int i = 0; i < 4; i++) send_acc(rand_grid());
    drain();
    end_test("acc_booking");
    for (int i = 0; i < 4; i++) send_feed(rand_grid());
    drain();
    end_test("feed_booking");
    // Same grid from both sides in one slot
    for (int i = 0; i < 3; i++) begin
      grid = rand_grid();
      fork
        send_acc(grid);
        send_feed(grid);
      join
      drain();
    end
    end_test("conflict");
    for (int i = 0; i < 30; i++) begin
      fork
        if ($urandom % 4 != 0) send_acc(rand_grid());
        if ($urandom % 4 != 0) send_feed(rand_grid());
      join
    end
    drain();
    end_test("random_mix");
    $display("Tests run %0d, tests failed %0d, assertion errors %0d",
             tests_run, tests_failed, chk0.err_cnt);
    if (tests_failed == 0 && chk0.err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Overall limit on the run
  initial begin
    #2000000;
    abort_run("simulation ran past its time limit");
  end

endmodule

// File: bench/gram_arb_checks.sv
// --------------------
// GRAM arbiter checker
// Concurrent checks on the top level ports, error counter for the bench
// --------------------

`timescale 1ns/100ps

`include "gram_arb_defines.svh"

module gram_arb_checks
  import gram_cmd_pkg::*;
(
  input logic                clk,
  input logic                s_rst_n,
  input gram_cmd_t           feed_req_i,
  input logic                feed_req_vld_i,
  input logic                feed_req_rdy_o,
  input gram_cmd_t           acc_req_i,
  input logic                acc_req_vld_i,
  input logic                acc_req_rdy_o,
  input logic                feed_grant_o,
  input logic                acc_grant_o,
  input logic [`GRAM_NB-1:0] feed_rot_avail_o,
  input logic [`GRAM_NB-1:0] feed_dat_avail_o,
  input logic [`GRAM_NB-1:0] acc_rd_avail_o,
  input logic [`GRAM_NB-1:0] acc_wr_avail_o,
  input logic [`GRAM_NB-1:0] sxt_avail_o,
  input logic [`GRAM_NB-1:0] ldg_avail_o
);

  int                    err_cnt = 0;
  int                    cyc_cnt;
  logic                  seen_req;
  logic [`GRAM_ID_W-1:0] acc_grid_q;
  logic [`GRAM_ID_W-1:0] feed_grid_q;
  logic                  no_runs;
  logic                  same_grid_take;
  logic                  acc_first_q;

  // No acc or feed run visible on any GRAM
  assign no_runs = !(|acc_rd_avail_o) && !(|acc_wr_avail_o)
                   && !(|feed_rot_avail_o) && !(|feed_dat_avail_o);

  // Both commands taken on one edge for one grid
  assign same_grid_take = acc_req_vld_i && acc_req_rdy_o
                          && feed_req_vld_i && feed_req_rdy_o
                          && (acc_req_i.grid == feed_req_i.grid);

  // Cycle count since reset and grids of the commands in flight
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      cyc_cnt     <= 0;
      seen_req    <= 1'b0;
      acc_grid_q  <= '0;
      feed_grid_q <= '0;
      acc_first_q <= 1'b0;
    end else begin
      cyc_cnt <= cyc_cnt + 1;
      if (acc_req_vld_i || feed_req_vld_i) seen_req <= 1'b1;
      if (acc_req_vld_i && acc_req_rdy_o) acc_grid_q <= acc_req_i.grid;
      if (feed_req_vld_i && feed_req_rdy_o) feed_grid_q <= feed_req_i.grid;
      // Pending until the acc grant of a contested free grid
      if (same_grid_take && no_runs) begin
        acc_first_q <= 1'b1;
      end else if (acc_grant_o) begin
        acc_first_q <= 1'b0;
      end
    end
  end

  // --------------------
  // Reset and idle fill
  // --------------------
  a_reset_state: assert property (@(posedge clk) $rose(s_rst_n) |->
    (ldg_avail_o == '0) && (sxt_avail_o == '0) && (acc_rd_avail_o == '0)
    && (acc_wr_avail_o == '0) && (feed_rot_avail_o == '0) && (feed_dat_avail_o == '0)
    && !acc_grant_o && !feed_grant_o && acc_req_rdy_o && feed_req_rdy_o)
    else begin
      err_cnt++;
      $error("ERR after reset acc_grant_o=%h feed_grant_o=%h acc_req_rdy_o=%h ldg_avail_o=%h",
             acc_grant_o, feed_grant_o, acc_req_rdy_o, ldg_avail_o);
    end

  // Slot zero goes to the opportunists once the first slot has ended
  a_idle_fill: assert property (@(posedge clk) disable iff (!s_rst_n)
    (cyc_cnt >= `GARB_SLOT_CYCLE + 1 && !seen_req) |-> (&ldg_avail_o) && (&sxt_avail_o))
    else begin
      err_cnt++;
      $error("ERR idle ldg_avail_o=%h sxt_avail_o=%h", ldg_avail_o, sxt_avail_o);
    end

  // Two grants of one round never share a grid
  a_acc_first: assert property (@(posedge clk) disable iff (!s_rst_n)
    (acc_grant_o && feed_grant_o) |-> (acc_grid_q != feed_grid_q))
    else begin
      err_cnt++;
      $error("ERR same grid granted acc_grid=%h feed_grid=%h", acc_grid_q, feed_grid_q);
    end

  // Contested free grid goes to the accumulator first
  a_acc_wins: assert property (@(posedge clk) disable iff (!s_rst_n)
    acc_first_q |-> !feed_grant_o)
    else begin
      err_cnt++;
      $error("ERR feed_grant_o=%h before acc_grant_o=%h feed_grid=%h",
             feed_grant_o, acc_grant_o, feed_grid_q);
    end

  // --------------------
  // Per GRAM port usage
  // --------------------
  for (genvar g = 0; g < `GRAM_NB; g++) begin : g_gram
    a_port_a_excl: assert property (@(posedge clk) disable iff (!s_rst_n)
      $onehot0({feed_rot_avail_o[g], acc_rd_avail_o[g], ldg_avail_o[g]}))
      else begin
        err_cnt++;
        $error("ERR gram %0d feed_rot_avail_o=%h acc_rd_avail_o=%h ldg_avail_o=%h",
               g, feed_rot_avail_o, acc_rd_avail_o, ldg_avail_o);
      end
    a_port_b_excl: assert property (@(posedge clk) disable iff (!s_rst_n)
      $onehot0({feed_dat_avail_o[g], acc_wr_avail_o[g], sxt_avail_o[g]}))
      else begin
        err_cnt++;
        $error("ERR gram %0d feed_dat_avail_o=%h acc_wr_avail_o=%h sxt_avail_o=%h",
               g, feed_dat_avail_o, acc_wr_avail_o, sxt_avail_o);
      end
    // Read run of 3 slots, then write run of 4 slots two slots in
    a_acc_rd: assert property (@(posedge clk) disable iff (!s_rst_n)
      (acc_grant_o && acc_grid_q == g) |=> acc_rd_avail_o[g] [*12])
      else begin
        err_cnt++;
        $error("ERR gram %0d acc_rd_avail_o=%h", g, acc_rd_avail_o);
      end
    a_acc_wr: assert property (@(posedge clk) disable iff (!s_rst_n)
      (acc_grant_o && acc_grid_q == g) |-> ##9 acc_wr_avail_o[g] [*16])
      else begin
        err_cnt++;
        $error("ERR gram %0d acc_wr_avail_o=%h", g, acc_wr_avail_o);
      end
    a_feed_rot: assert property (@(posedge clk) disable iff (!s_rst_n)
      (feed_grant_o && feed_grid_q == g) |=> feed_rot_avail_o[g] [*12])
      else begin
        err_cnt++;
        $error("ERR gram %0d feed_rot_avail_o=%h", g, feed_rot_avail_o);
      end
    // Feed data follows one slot after the rotation start
    a_feed_dat: assert property (@(posedge clk) disable iff (!s_rst_n)
      (feed_grant_o && feed_grid_q == g) |-> ##5 feed_dat_avail_o[g] [*16])
      else begin
        err_cnt++;
        $error("ERR gram %0d feed_dat_avail_o=%h", g, feed_dat_avail_o);
      end
  end

  // --------------------
  // Back-pressure
  // --------------------
  a_acc_hold: assert property (@(posedge clk) disable iff (!s_rst_n)
    ((acc_req_vld_i && acc_req_rdy_o) or (!acc_req_rdy_o && !acc_grant_o))
    |=> !acc_req_rdy_o)
    else begin
      err_cnt++;
      $error("ERR acc_req_rdy_o=%h before grant", acc_req_rdy_o);
    end
  a_acc_once: assert property (@(posedge clk) disable iff (!s_rst_n)
    acc_grant_o |-> !acc_req_rdy_o ##1 acc_req_rdy_o)
    else begin
      err_cnt++;
      $error("ERR acc_grant_o=%h acc_req_rdy_o=%h", acc_grant_o, acc_req_rdy_o);
    end
  a_feed_hold: assert property (@(posedge clk) disable iff (!s_rst_n)
    ((feed_req_vld_i && feed_req_rdy_o) or (!feed_req_rdy_o && !feed_grant_o))
    |=> !feed_req_rdy_o)
    else begin
      err_cnt++;
      $error("ERR feed_req_rdy_o=%h before grant", feed_req_rdy_o);
    end
  a_feed_once: assert property (@(posedge clk) disable iff (!s_rst_n)
    feed_grant_o |-> !feed_req_rdy_o ##1 feed_req_rdy_o)
    else begin
      err_cnt++;
      $error("ERR feed_grant_o=%h feed_req_rdy_o=%h", feed_grant_o, feed_req_rdy_o);
    end

endmodule

// File: source/gram_arb_top.sv
// --------------------
// GRAM slot arbiter
// Feed and accumulator requests in, grants and
// per-slot avail buses out
// --------------------

`timescale 1ns/100ps

`include "gram_arb_defines.svh"

module gram_arb_top
  import gram_cmd_pkg::*;
(
  input  logic               clk,
  input  logic               s_rst_n,
  // Feed requester
  input  gram_cmd_t          feed_req_i,
  input  logic               feed_req_vld_i,
  output logic               feed_req_rdy_o,
  // Accumulator requester
  input  gram_cmd_t          acc_req_i,
  input  logic               acc_req_vld_i,
  output logic               acc_req_rdy_o,
  // Grants
  output logic               feed_grant_o,
  output logic               acc_grant_o,
  // Current slot owners, one bit per GRAM
  output logic [`GRAM_NB-1:0] feed_rot_avail_o,
  output logic [`GRAM_NB-1:0] feed_dat_avail_o,
  output logic [`GRAM_NB-1:0] acc_rd_avail_o,
  output logic [`GRAM_NB-1:0] acc_wr_avail_o,
  output logic [`GRAM_NB-1:0] sxt_avail_o,
  output logic [`GRAM_NB-1:0] ldg_avail_o
);

  gram_cmd_t                      feed_cmd;
  logic                           feed_cmd_vld;
  logic                           feed_release;
  gram_cmd_t                      acc_cmd;
  logic                           acc_cmd_vld;
  logic                           acc_release;
  logic                           slot_last;
  logic                           arb_acc;
  logic                           arb_feed;
  logic                           arb_grant;
  logic [`GRAM_NB-1:0][REQ_NB-1:0] book_mask;
  logic [1:0][`GRAM_NB-1:0]       slot_free;
  logic [REQ_NB-1:0]              start_free;
  logic [REQ_NB-1:0]              owner_now;

  // --------------------
  // Request buffers
  // --------------------
  gram_req_pipe feed_pipe (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .req_i     (feed_req_i),
    .req_vld_i (feed_req_vld_i),
    .req_rdy_o (feed_req_rdy_o),
    .cmd_o     (feed_cmd),
    .cmd_vld_o (feed_cmd_vld),
    .release_i (feed_release)
  );

  gram_req_pipe acc_pipe (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .req_i     (acc_req_i),
    .req_vld_i (acc_req_vld_i),
    .req_rdy_o (acc_req_rdy_o),
    .cmd_o     (acc_cmd),
    .cmd_vld_o (acc_cmd_vld),
    .release_i (acc_release)
  );

  // Slot clocking and step strobes
  gram_slot_timer slot_timer (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .slot_last_o (slot_last),
    .arb_acc_o   (arb_acc),
    .arb_feed_o  (arb_feed),
    .arb_grant_o (arb_grant)
  );

  gram_arb_decide arb_decide (
    .clk            (clk),
    .s_rst_n        (s_rst_n),
    .feed_cmd_i     (feed_cmd),
    .feed_vld_i     (feed_cmd_vld),
    .acc_cmd_i      (acc_cmd),
    .acc_vld_i      (acc_cmd_vld),
    .arb_acc_i      (arb_acc),
    .arb_feed_i     (arb_feed),
    .arb_grant_i    (arb_grant),
    .slot_free_i    (slot_free),
    .start_free_i   (start_free),
    .owner_now_i    (owner_now),
    .book_mask_o    (book_mask),
    .feed_grant_o   (feed_grant_o),
    .acc_grant_o    (acc_grant_o),
    .feed_release_o (feed_release),
    .acc_release_o  (acc_release)
  );

  gram_plan_table plan_table (
    .clk              (clk),
    .s_rst_n          (s_rst_n),
    .slot_last_i      (slot_last),
    .book_mask_i      (book_mask),
    .feed_grid_i      (feed_cmd.grid),
    .acc_grid_i       (acc_cmd.grid),
    .slot_free_o      (slot_free),
    .start_free_o     (start_free),
    .owner_now_o      (owner_now),
    .feed_rot_avail_o (feed_rot_avail_o),
    .feed_dat_avail_o (feed_dat_avail_o),
    .acc_rd_avail_o   (acc_rd_avail_o),
    .acc_wr_avail_o   (acc_wr_avail_o),
    .sxt_avail_o      (sxt_avail_o),
    .ldg_avail_o      (ldg_avail_o)
  );

endmodule

// File: source/gram_plan_table.sv
// --------------------
// Planning table
// Books winners, fills idle slots for the opportunists,
// shifts the window each slot and drives the avail buses
// --------------------

`timescale 1ns/100ps

`include "gram_arb_defines.svh"

module gram_plan_table
  import gram_cmd_pkg::*;
  import gram_plan_pkg::*;
(
  input  logic                            clk,
  input  logic                            s_rst_n,
  input  logic                            slot_last_i,
  input  logic [`GRAM_NB-1:0][REQ_NB-1:0] book_mask_i,
  input  logic [`GRAM_ID_W-1:0]           feed_grid_i,
  input  logic [`GRAM_ID_W-1:0]           acc_grid_i,
  output logic [1:0][`GRAM_NB-1:0]        slot_free_o,
  output logic [REQ_NB-1:0]               start_free_o,
  output logic [REQ_NB-1:0]               owner_now_o,
  output logic [`GRAM_NB-1:0]             feed_rot_avail_o,
  output logic [`GRAM_NB-1:0]             feed_dat_avail_o,
  output logic [`GRAM_NB-1:0]             acc_rd_avail_o,
  output logic [`GRAM_NB-1:0]             acc_wr_avail_o,
  output logic [`GRAM_NB-1:0]             sxt_avail_o,
  output logic [`GRAM_NB-1:0]             ldg_avail_o
);

  localparam int SLOT_NB    = `GARB_SLOT_NB;
  localparam int PB_RUN     = `GLWE_SLOT_NB + `PB_ADD_SLOT;
  localparam int ACC_START  = `ARB_SLOT + `ACC_WR_DLY_SLOT;
  localparam int FEED_START = `ARB_SLOT + `FEED_DAT_DLY_SLOT;

  // [port][gram] rows
  plan_row_t [1:0][`GRAM_NB-1:0] plan_q;
  plan_row_t [1:0][`GRAM_NB-1:0] plan_upd;
  plan_row_t [1:0][`GRAM_NB-1:0] plan_d;
  logic                          entry_ok;

  // --------------------
  // Lookups for the decider
  // --------------------
  always_comb begin
    owner_now_o = '0;
    for (int g = 0; g < `GRAM_NB; g++) begin
      slot_free_o[PORT_A][g] = (plan_q[PORT_A][g][`ARB_SLOT] == SRC_NONE);
      slot_free_o[PORT_B][g] = (plan_q[PORT_B][g][`ARB_SLOT] == SRC_NONE);
      // Earlier run still running on port A, any GRAM
      owner_now_o[REQ_ACC]  |= (plan_q[PORT_A][g][`ARB_SLOT] == SRC_ACC);
      owner_now_o[REQ_FEED] |= (plan_q[PORT_A][g][`ARB_SLOT] == SRC_FEED);
    end
    // Port B start of each requester on its own grid
    start_free_o[REQ_ACC]  = (plan_q[PORT_B][acc_grid_i][ACC_START] == SRC_NONE);
    start_free_o[REQ_FEED] = (plan_q[PORT_B][feed_grid_i][FEED_START] == SRC_NONE);
  end

  // --------------------
  // Booking and fill
  // --------------------
  always_comb begin
    plan_upd = plan_q;
    for (int g = 0; g < `GRAM_NB; g++) begin
      // Port A run from ARB_SLOT
      for (int i = 0; i < `GLWE_SLOT_NB; i++) begin
        if (book_mask_i[g][REQ_ACC]) plan_upd[PORT_A][g][`ARB_SLOT+i] = SRC_ACC;
        if (book_mask_i[g][REQ_FEED]) plan_upd[PORT_A][g][`ARB_SLOT+i] = SRC_FEED;
      end
      // Delayed port B run, one slot longer
      for (int i = 0; i < PB_RUN; i++) begin
        if (book_mask_i[g][REQ_ACC]) plan_upd[PORT_B][g][ACC_START+i] = SRC_ACC;
        if (book_mask_i[g][REQ_FEED]) plan_upd[PORT_B][g][FEED_START+i] = SRC_FEED;
      end
      // What nobody booked goes to load (A) and sign-extension (B)
      for (int p = 0; p < 2; p++) begin
        if (plan_upd[p][g][`ARB_SLOT] == SRC_NONE) begin
          plan_upd[p][g][`ARB_SLOT] = SRC_OPP;
        end
      end
    end
  end

  // Window moves one slot at each slot end
  always_comb begin
    plan_d = plan_q;
    if (slot_last_i) begin
      for (int p = 0; p < 2; p++) begin
        for (int g = 0; g < `GRAM_NB; g++) begin
          for (int j = 0; j < SLOT_NB - 1; j++) begin
            plan_d[p][g][j] = plan_upd[p][g][j+1];
          end
          plan_d[p][g][SLOT_NB-1] = SRC_NONE;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      plan_q <= '0;
    end else begin
      plan_q <= plan_d;
    end
  end

  // --------------------
  // Current slot outputs
  // --------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      feed_rot_avail_o <= '0;
      feed_dat_avail_o <= '0;
      acc_rd_avail_o   <= '0;
      acc_wr_avail_o   <= '0;
      sxt_avail_o      <= '0;
      ldg_avail_o      <= '0;
    end else begin
      for (int g = 0; g < `GRAM_NB; g++) begin
        feed_rot_avail_o[g] <= (plan_q[PORT_A][g][0] == SRC_FEED);
        feed_dat_avail_o[g] <= (plan_q[PORT_B][g][0] == SRC_FEED);
        acc_rd_avail_o[g]   <= (plan_q[PORT_A][g][0] == SRC_ACC);
        acc_wr_avail_o[g]   <= (plan_q[PORT_B][g][0] == SRC_ACC);
        sxt_avail_o[g]      <= (plan_q[PORT_B][g][0] == SRC_OPP);
        ldg_avail_o[g]      <= (plan_q[PORT_A][g][0] == SRC_OPP);
      end
    end
  end

  // Every entry holds at most one owner
  always_comb begin
    entry_ok = 1'b1;
    for (int p = 0; p < 2; p++) begin
      for (int g = 0; g < `GRAM_NB; g++) begin
        for (int j = 0; j < SLOT_NB; j++) begin
          if (!$onehot0(plan_q[p][g][j])) entry_ok = 1'b0;
        end
      end
    end
  end

  a_entry_onehot: assert property (@(posedge clk) disable iff (!s_rst_n) entry_ok)
    else $error("ERR plan_q entry not one-hot, entry_ok=%h", entry_ok);

endmodule

// File: source/gram_arb_decide.sv
// --------------------
// Round decisions
// Picks the accumulator grid then the feed grid
// Drives the booking mask, grant and release pulses
// --------------------

`timescale 1ns/100ps

`include "gram_arb_defines.svh"

module gram_arb_decide
  import gram_cmd_pkg::*;
  import gram_plan_pkg::*;
(
  input  logic                           clk,
  input  logic                           s_rst_n,
  // Held commands
  input  gram_cmd_t                      feed_cmd_i,
  input  logic                           feed_vld_i,
  input  gram_cmd_t                      acc_cmd_i,
  input  logic                           acc_vld_i,
  // Step strobes
  input  logic                           arb_acc_i,
  input  logic                           arb_feed_i,
  input  logic                           arb_grant_i,
  // Table state
  input  logic [1:0][`GRAM_NB-1:0]       slot_free_i,
  input  logic [REQ_NB-1:0]              start_free_i,
  input  logic [REQ_NB-1:0]              owner_now_i,
  // Decisions
  output logic [`GRAM_NB-1:0][REQ_NB-1:0] book_mask_o,
  output logic                           feed_grant_o,
  output logic                           acc_grant_o,
  output logic                           feed_release_o,
  output logic                           acc_release_o
);

  logic [`GRAM_NB-1:0] acc_mask_d;
  logic [`GRAM_NB-1:0] acc_mask_q;
  logic [`GRAM_NB-1:0] feed_mask_d;
  logic [`GRAM_NB-1:0] feed_mask_q;
  logic                acc_grant_q;
  logic                feed_grant_q;

  // --------------------
  // Candidate grids
  // --------------------
  // Table does not move during the round, so all steps see the same state
  always_comb begin
    for (int g = 0; g < `GRAM_NB; g++) begin
      // Accumulator: port A free now, port B free at its write start,
      // and no earlier acc run still at ARB_SLOT
      acc_mask_d[g] = acc_vld_i
                      && (acc_cmd_i.grid == g[`GRAM_ID_W-1:0])
                      && slot_free_i[PORT_A][g]
                      && start_free_i[REQ_ACC]
                      && !owner_now_i[REQ_ACC];
      // Feed: same rules, but loses the grid the acc took this round
      feed_mask_d[g] = feed_vld_i
                       && (feed_cmd_i.grid == g[`GRAM_ID_W-1:0])
                       && slot_free_i[PORT_A][g]
                       && start_free_i[REQ_FEED]
                       && !owner_now_i[REQ_FEED]
                       && !acc_mask_q[g];
    end
  end

  // Each step captures its own decision
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      acc_mask_q  <= '0;
      feed_mask_q <= '0;
    end else begin
      if (arb_acc_i) begin
        acc_mask_q <= acc_mask_d;
      end
      if (arb_feed_i) begin
        feed_mask_q <= feed_mask_d;
      end
    end
  end

  // --------------------
  // Grant step
  // --------------------
  // Booking mask only meaningful on the grant clock
  always_comb begin
    for (int g = 0; g < `GRAM_NB; g++) begin
      book_mask_o[g][REQ_ACC]  = arb_grant_i & acc_mask_q[g];
      book_mask_o[g][REQ_FEED] = arb_grant_i & feed_mask_q[g];
    end
  end

  // One clock pulse, right after the table takes the booking
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      acc_grant_q  <= 1'b0;
      feed_grant_q <= 1'b0;
    end else begin
      acc_grant_q  <= arb_grant_i & (|acc_mask_q);
      feed_grant_q <= arb_grant_i & (|feed_mask_q);
    end
  end

  assign acc_grant_o    = acc_grant_q;
  assign feed_grant_o   = feed_grant_q;
  // Release frees the request pipe on the grant itself
  assign acc_release_o  = acc_grant_q;
  assign feed_release_o = feed_grant_q;

  // Acc and feed decided on different clocks must never share a GRAM
  for (genvar g = 0; g < `GRAM_NB; g++) begin : g_excl
    a_one_src: assert property (@(posedge clk) disable iff (!s_rst_n)
      $onehot0(book_mask_o[g]))
      else $error("ERR book_mask_o[%0d]=%h", g, book_mask_o[g]);
  end

endmodule

// File: source/gram_slot_timer.sv
// --------------------
// Slot timer
// Counts clocks in a slot and steps the arbitration sequence
// acc, feed and grant on the last three clocks
// --------------------

`timescale 1ns/100ps

`include "gram_arb_defines.svh"

module gram_slot_timer (
  input  logic clk,
  input  logic s_rst_n,
  output logic slot_last_o,
  output logic arb_acc_o,
  output logic arb_feed_o,
  output logic arb_grant_o
);

  localparam int CNT_W     = $clog2(`GARB_SLOT_CYCLE);
  // Three arbitration steps, started when this many clocks are left
  localparam int ARB_STEPS = 3;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACC,
    ST_FEED,
    ST_GRANT
  } state_e;

  logic [CNT_W-1:0] slot_cnt;
  state_e           state;
  state_e           next_state;

  // --------------------
  // Slot countdown
  // --------------------
  assign slot_last_o = (slot_cnt == '0);

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      slot_cnt <= CNT_W'(`GARB_SLOT_CYCLE - 1);
    end else if (slot_last_o) begin
      slot_cnt <= CNT_W'(`GARB_SLOT_CYCLE - 1);
    end else begin
      slot_cnt <= slot_cnt - 1'b1;
    end
  end

  // --------------------
  // Step sequencer
  // --------------------
  always_comb begin
    case (state)
      ST_IDLE:  next_state = (slot_cnt == CNT_W'(ARB_STEPS)) ? ST_ACC : ST_IDLE;
      ST_ACC:   next_state = ST_FEED;
      ST_FEED:  next_state = ST_GRANT;
      default:  next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= next_state;
    end
  end

  assign arb_acc_o   = (state == ST_ACC);
  assign arb_feed_o  = (state == ST_FEED);
  assign arb_grant_o = (state == ST_GRANT);

  // Table update and grant must land on the same edge
  a_grant_on_last: assert property (@(posedge clk) disable iff (!s_rst_n)
    arb_grant_o |-> slot_last_o)
    else $error("ERR arb_grant_o=%h slot_cnt=%h", arb_grant_o, slot_cnt);

endmodule

// File: source/gram_req_pipe.sv
// --------------------
// Request holding buffer
// Keeps one command from acceptance until its grant
// --------------------

`timescale 1ns/100ps

`include "gram_arb_defines.svh"

module gram_req_pipe
  import gram_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      s_rst_n,
  input  gram_cmd_t req_i,
  input  logic      req_vld_i,
  output logic      req_rdy_o,
  output gram_cmd_t cmd_o,
  output logic      cmd_vld_o,
  input  logic      release_i
);

  logic      full_q;
  gram_cmd_t cmd_q;

  // Only accept while empty
  assign req_rdy_o = ~full_q;
  assign cmd_vld_o = full_q;
  assign cmd_o     = cmd_q;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      full_q <= 1'b0;
    end else if (req_vld_i && req_rdy_o) begin
      full_q <= 1'b1;
    end else if (release_i) begin
      // Granted, slot handed back to the requester
      full_q <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (req_vld_i && req_rdy_o) begin
      cmd_q <= req_i;
    end
  end

  // A grant can only consume a command that is held here
  a_release_when_full: assert property (@(posedge clk) disable iff (!s_rst_n)
    release_i |-> full_q)
    else $error("ERR release_i=%h while pipe empty", release_i);

endmodule

// File: source/gram_plan_pkg.sv
// --------------------
// Planning table types
// Slot owners, RAM ports and one planning row
// --------------------

`include "gram_arb_defines.svh"

package gram_plan_pkg;

  // Slot owner, one-hot
  // Zero means nobody holds the slot yet
  typedef enum logic [2:0] {
    SRC_NONE = 3'b000,
    SRC_FEED = 3'b001,
    SRC_ACC  = 3'b010,
    SRC_OPP  = 3'b100
  } src_e;

  // GRAM is a 2RW RAM
  // Port A for feed rot, acc rd and load
  // Port B for feed dat, acc wr and sign-extension
  typedef enum logic {
    PORT_A = 1'b0,
    PORT_B = 1'b1
  } port_e;

  // Owners of the future slots of one port of one GRAM
  // Index 0 is the slot being executed
  typedef src_e [`GARB_SLOT_NB-1:0] plan_row_t;

endpackage

// File: source/gram_cmd_pkg.sv
// --------------------
// Request side types
// Command word and requester indices
// --------------------

`include "gram_arb_defines.svh"

package gram_cmd_pkg;

  // Command carries only the target grid
  typedef struct packed {
    logic [`GRAM_ID_W-1:0] grid;
  } gram_cmd_t;

  // Requester indices
  // Used to address per-requester vectors
  localparam int REQ_FEED = 0;
  localparam int REQ_ACC  = 1;
  localparam int REQ_NB   = 2;

endpackage

// File: source/gram_arb_defines.svh
// --------------------
// GRAM arbiter constants
// Bank size, slot timing and booking lengths shared by all blocks
// --------------------

`ifndef GRAM_ARB_DEFINES_SVH
`define GRAM_ARB_DEFINES_SVH

// Bank of GRAMs, one grid index selects one of them
`define GRAM_NB            4
`define GRAM_ID_W          2

// Slot timing
// Clocks per slot and depth of the planning window
`define GARB_SLOT_CYCLE    4
`define GARB_SLOT_NB       8

// Slot that a round of arbitration books into
`define ARB_SLOT           1

// Port A run length per grant
`define GLWE_SLOT_NB       3

// Port B run starts this many slots after ARB_SLOT
`define ACC_WR_DLY_SLOT    2
`define FEED_DAT_DLY_SLOT  1
// Port B run is longer than the port A one
`define PB_ADD_SLOT        1

`endif
